//--- uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// clock cycles per serial bit, one line rate per build
`define UART_CLKS_PER_BIT 16

// depth of the transform input buffer
// also the starting credit count of the receiver
`define XFORM_IN_CREDITS 4

// depth of the transmitter holding buffer
// also the starting credit count of the transform
`define XFORM_OUT_CREDITS 4

`endif

//--- line_pkg.sv
package line_pkg;

  // one byte on a credit link
  typedef struct packed {
    logic [7:0] data;
  } byte_beat_t;

  // receiver frame states
  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_e;

  // transmitter frame states
  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_e;

endpackage

//--- xform_pkg.sv
package xform_pkg;

  // transform mode, value matches the low bits of the command byte
  typedef enum logic [1:0] {
    xform_pass   = 2'd0,
    xform_upper  = 2'd1,
    xform_lower  = 2'd2,
    xform_invert = 2'd3
  } xform_op_e;

  // command bytes are 0xf0 .. 0xf3
  localparam logic [7:0] cmd_base = 8'hF0;

  // bits that must match cmd_base for a command
  localparam logic [7:0] cmd_mask = 8'hFC;

  function automatic logic is_cmd_byte(logic [7:0] b);
    return (b & cmd_mask) == cmd_base;
  endfunction

endpackage

//--- uart_rx.sv
`timescale 1ns/1ns
`include "uart_settings.svh"

module uart_rx
  import line_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       rx,
  output byte_beat_t in_beat,
  output logic       in_valid,
  input  logic       in_credit,
  output logic       frame_err,
  output logic       overrun
);

  localparam int sub_w = $clog2(`UART_CLKS_PER_BIT);
  localparam int cred_w = $clog2(`XFORM_IN_CREDITS + 1);

  rx_state_e state;

  logic [sub_w-1:0]  sub_cnt;
  logic [2:0]        bit_cnt;
  logic [7:0]        shift;
  logic              rx_prev;
  logic [cred_w-1:0] credit_cnt;

  logic mid_bit;
  logic last_sub;
  logic stop_seen;
  logic stop_good;
  logic send;

  assign mid_bit = sub_cnt == sub_w'(`UART_CLKS_PER_BIT / 2 - 1);
  assign last_sub = sub_cnt == sub_w'(`UART_CLKS_PER_BIT - 1);

  // mid-stop sample and its outcome
  assign stop_seen = (state == rx_stop) && mid_bit;
  assign stop_good = stop_seen && rx;
  assign send = stop_good && (credit_cnt != '0);

  // byte stays stable in the shift register until the next frame's data
  assign in_beat = '{data: shift};

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= rx_idle;
      sub_cnt   <= '0;
      bit_cnt   <= '0;
      rx_prev   <= 1'b1;
      in_valid  <= 1'b0;
      frame_err <= 1'b0;
      overrun   <= 1'b0;
    end else begin
      rx_prev   <= rx;
      in_valid  <= send;
      overrun   <= stop_good && (credit_cnt == '0);
      frame_err <= stop_seen && !rx;

      case (state)
        rx_idle: begin
          // falling edge marks the start bit, this cycle counts as sub 0
          if (rx_prev && !rx) begin
            state   <= rx_start;
            sub_cnt <= sub_w'(1);
          end else begin
            sub_cnt <= '0;
          end
        end
        rx_start: begin
          sub_cnt <= last_sub ? '0 : sub_cnt + 1'b1;
          if (mid_bit) begin
            if (!rx) begin
              state   <= rx_data;
              bit_cnt <= '0;
            end else begin
              // glitch, not a real start bit
              state   <= rx_idle;
              sub_cnt <= '0;
            end
          end
        end
        rx_data: begin
          sub_cnt <= last_sub ? '0 : sub_cnt + 1'b1;
          if (mid_bit) begin
            // lsb first
            shift   <= {rx, shift[7:1]};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= rx_stop;
            end
          end
        end
        rx_stop: begin
          sub_cnt <= last_sub ? '0 : sub_cnt + 1'b1;
          if (mid_bit) begin
            state   <= rx_idle;
            sub_cnt <= '0;
          end
        end
        default: begin
          state <= rx_idle;
        end
      endcase
    end
  end

  // link a credits, starts at the transform buffer depth
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt <= cred_w'(`XFORM_IN_CREDITS);
    end else begin
      credit_cnt <= credit_cnt + cred_w'(in_credit) - cred_w'(send);
    end
  end

endmodule

//--- byte_transform.sv
`timescale 1ns/1ns
`include "uart_settings.svh"

module byte_transform
  import line_pkg::*;
  import xform_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  byte_beat_t in_beat,
  input  logic       in_valid,
  output logic       in_credit,
  output byte_beat_t out_beat,
  output logic       out_valid,
  input  logic       out_credit
);

  localparam int depth = `XFORM_IN_CREDITS;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);
  localparam int cred_w = $clog2(`XFORM_OUT_CREDITS + 1);

  byte_beat_t fifo_mem [depth];

  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  logic [cnt_w-1:0]  fill;
  logic [cred_w-1:0] credit_cnt;

  xform_op_e mode;

  byte_beat_t head;
  logic       head_cmd;
  logic       pop;
  logic       send;

  function automatic logic [ptr_w-1:0] next_ptr(logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  function automatic logic [7:0] apply_op(xform_op_e op, logic [7:0] b);
    case (op)
      // ascii case flips by bit 5
      xform_upper: return (b >= "a" && b <= "z") ? (b & 8'hDF) : b;
      xform_lower: return (b >= "A" && b <= "Z") ? (b | 8'h20) : b;
      xform_invert: return ~b;
      default: return b;
    endcase
  endfunction

  assign head = fifo_mem[rd_ptr];
  assign head_cmd = is_cmd_byte(head.data);

  // commands never wait, data needs a link b credit
  assign pop = (fill != '0) && (head_cmd || (credit_cnt != '0));
  assign send = pop && !head_cmd;

  always_ff @(posedge clk) begin
    if (in_valid) begin
      fifo_mem[wr_ptr] <= in_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      fill <= fill + cnt_w'(in_valid) - cnt_w'(pop);
    end
  end

  // mode register, pass after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      mode <= xform_pass;
    end else if (pop && head_cmd) begin
      mode <= xform_op_e'(head.data[1:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_credit <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      // every freed slot goes back to the receiver
      in_credit <= pop;
      out_valid <= send;
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      out_beat.data <= apply_op(mode, head.data);
    end
  end

  // link b credits, starts at the holding buffer depth
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt <= cred_w'(`XFORM_OUT_CREDITS);
    end else begin
      credit_cnt <= credit_cnt + cred_w'(out_credit) - cred_w'(send);
    end
  end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ns
`include "uart_settings.svh"

module uart_tx
  import line_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  byte_beat_t out_beat,
  input  logic       out_valid,
  output logic       out_credit,
  output logic       tx
);

  localparam int depth = `XFORM_OUT_CREDITS;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);
  localparam int sub_w = $clog2(`UART_CLKS_PER_BIT);

  logic [7:0] fifo_mem [depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] fill;

  tx_state_e state;

  logic [sub_w-1:0] sub_cnt;
  logic [2:0]       bit_cnt;
  logic [7:0]       shift;

  logic bit_end;
  logic load;

  function automatic logic [ptr_w-1:0] next_ptr(logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign bit_end = sub_cnt == sub_w'(`UART_CLKS_PER_BIT - 1);

  // load from idle, or straight from the last stop cycle so frames run back to back
  assign load = (fill != '0) && ((state == tx_idle) || ((state == tx_stop) && bit_end));

  always_ff @(posedge clk) begin
    if (out_valid) begin
      fifo_mem[wr_ptr] <= out_beat.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (out_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (load) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      fill <= fill + cnt_w'(out_valid) - cnt_w'(load);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= tx_idle;
      sub_cnt    <= '0;
      bit_cnt    <= '0;
      tx         <= 1'b1;
      out_credit <= 1'b0;
    end else begin
      out_credit <= load;
      if (load) begin
        shift   <= fifo_mem[rd_ptr];
        state   <= tx_start;
        sub_cnt <= '0;
        tx      <= 1'b0;
      end else begin
        sub_cnt <= bit_end ? '0 : sub_cnt + 1'b1;
        case (state)
          tx_idle: begin
            sub_cnt <= '0;
            tx      <= 1'b1;
          end
          tx_start: begin
            if (bit_end) begin
              state   <= tx_data;
              bit_cnt <= '0;
              tx      <= shift[0];
              shift   <= shift >> 1;
            end
          end
          tx_data: begin
            if (bit_end) begin
              if (bit_cnt == 3'd7) begin
                state <= tx_stop;
                tx    <= 1'b1;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
                tx      <= shift[0];
                shift   <= shift >> 1;
              end
            end
          end
          tx_stop: begin
            // nothing queued, line stays high
            if (bit_end) begin
              state <= tx_idle;
            end
          end
          default: begin
            state <= tx_idle;
          end
        endcase
      end
    end
  end

endmodule

//--- uart_xform_top.sv
`timescale 1ns/1ns

module uart_xform_top
  import line_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic rx,
  output logic tx,
  output logic frame_err,
  output logic overrun
);

  // link a, receiver to transform
  byte_beat_t in_beat;
  logic       in_valid;
  logic       in_credit;

  // link b, transform to transmitter
  byte_beat_t out_beat;
  logic       out_valid;
  logic       out_credit;

  uart_rx uart_rx_i (
    .clk       (clk),
    .rst       (rst),
    .rx        (rx),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_credit (in_credit),
    .frame_err (frame_err),
    .overrun   (overrun)
  );

  byte_transform byte_transform_i (
    .clk        (clk),
    .rst        (rst),
    .in_beat    (in_beat),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_beat   (out_beat),
    .out_valid  (out_valid),
    .out_credit (out_credit)
  );

  uart_tx uart_tx_i (
    .clk        (clk),
    .rst        (rst),
    .out_beat   (out_beat),
    .out_valid  (out_valid),
    .out_credit (out_credit),
    .tx         (tx)
  );

endmodule

//--- uart_xform_properties.sv
`timescale 1ns/1ns

module uart_xform_properties #(
  parameter int depth = 4,
  parameter int cnt_w = $clog2(depth + 1)
) (
  input logic             clk,
  input logic             rst,
  input logic             push,
  input logic [cnt_w-1:0] fill,
  input logic             idle
);

  // a credit in hand means a free slot at the receiver
  push_has_slot: assert property (
    @(posedge clk) disable iff (rst)
    push |-> (fill < cnt_w'(depth))
  ) else $error("beat pushed into a full buffer");

  fill_in_range: assert property (
    @(posedge clk) disable iff (rst)
    fill <= cnt_w'(depth)
  ) else $error("buffer occupancy above its depth");

  // outputs at rest once reset is released
  idle_after_reset: assert property (
    @(posedge clk)
    $fell(rst) |-> idle
  ) else $error("outputs not at rest after reset");

endmodule

//--- tb_uart_xform.sv
`timescale 1ns/1ns
`include "uart_settings.svh"

module tb_uart_xform
  import line_pkg::*;
  import xform_pkg::*;
();

  localparam int cpb = `UART_CLKS_PER_BIT;
  localparam logic [31:0] seed_init = 32'h62f6;
  localparam int n_pass = 8;
  localparam int n_mode = 24;
  localparam int n_random = 200;
  localparam int n_framing = 2;
  localparam int n_burst = 16;
  localparam int frame_total = n_pass + n_mode + n_random + n_framing + n_burst;
  localparam int timeout_cycles = frame_total * 12 * cpb + 200;

  logic clk;
  logic rst;
  logic rx;
  logic tx;
  logic frame_err;
  logic overrun;

  integer     seed;
  int         cycle_count = 0;
  int         frame_err_count = 0;
  int         overrun_count = 0;
  xform_op_e  model_mode;
  byte_beat_t exp_q[$];
  xform_op_e  exp_mode_q[$];
  xform_op_e  dut_mode_q[$];

  logic [7:0] cmd_seq [4] = '{8'hF1, 8'hF2, 8'hF3, 8'hF0};
  // 'a' 'Z' 'm' '7' '~'
  logic [7:0] text [5] = '{8'h61, 8'h5A, 8'h6D, 8'h37, 8'h7E};

  uart_xform_top uart_xform_top_i (
    .clk       (clk),
    .rst       (rst),
    .rx        (rx),
    .tx        (tx),
    .frame_err (frame_err),
    .overrun   (overrun)
  );

  bind byte_transform uart_xform_properties #(.depth(`XFORM_IN_CREDITS)) transform_props_i (
    .clk  (clk),
    .rst  (rst),
    .push (in_valid),
    .fill (fill),
    .idle (!in_credit && !out_valid)
  );

  bind uart_tx uart_xform_properties #(.depth(`XFORM_OUT_CREDITS)) tx_props_i (
    .clk  (clk),
    .rst  (rst),
    .push (out_valid),
    .fill (fill),
    .idle (tx && !out_credit)
  );

  always #10 clk = ~clk;

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic compare_byte(input string name, input byte_beat_t got, input byte_beat_t exp);
    if (got != exp) begin
      stop_on_failure($sformatf("error: %s got 0x%02h expected 0x%02h",
                                name, got.data, exp.data));
    end
  endtask

  task automatic compare_mode(input string name, input xform_op_e got, input xform_op_e exp);
    if (got != exp) begin
      stop_on_failure($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_on_failure($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic is_command(logic [7:0] b);
    return b[7:2] == cmd_base[7:2];
  endfunction

  // reference rule for one data byte
  function automatic logic [7:0] expected_byte(xform_op_e op, logic [7:0] b);
    logic [7:0] r;
    r = b;
    case (op)
      xform_upper: begin
        if (b >= 8'h61 && b <= 8'h7A) begin
          r = b - 8'd32;
        end
      end
      xform_lower: begin
        if (b >= 8'h41 && b <= 8'h5A) begin
          r = b + 8'd32;
        end
      end
      xform_invert: begin
        r = 8'hFF - b;
      end
      default: begin
        r = b;
      end
    endcase
    return r;
  endfunction

  task automatic model_byte(input logic [7:0] b);
    byte_beat_t beat;
    if (is_command(b)) begin
      model_mode = xform_op_e'(b[1:0]);
    end else begin
      beat.data = expected_byte(model_mode, b);
      exp_q.push_back(beat);
      exp_mode_q.push_back(model_mode);
    end
  endtask

  function automatic logic [7:0] random_data();
    logic [7:0] b;
    b = 8'($random(seed));
    if (is_command(b)) begin
      // move it to 0xe0..0xe3
      b[4] = 1'b0;
    end
    return b;
  endfunction

  function automatic logic [7:0] random_byte();
    logic [31:0] r;
    r = $random(seed);
    // about one byte in eight is a mode command
    if (r[2:0] == 3'd0) begin
      return cmd_base | {6'd0, r[4:3]};
    end
    return random_data();
  endfunction

  task automatic drive_bit(input logic v);
    rx <= v;
    repeat (cpb) @(posedge clk);
  endtask

  task automatic drive_frame(input logic [7:0] b, input logic stop_bit, input int gap_bits);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(stop_bit);
    repeat (gap_bits) begin
      drive_bit(1'b1);
    end
  endtask

  task automatic send_byte(input logic [7:0] b, input int gap_bits);
    model_byte(b);
    drive_frame(b, 1'b1, gap_bits);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    // rest of the last stop bit
    repeat (cpb) @(posedge clk);
  endtask

  // entered one cycle into the start bit
  task automatic receive_frame();
    byte_beat_t got;
    byte_beat_t exp;
    xform_op_e  exp_mode;
    xform_op_e  dut_mode;
    got.data = '0;
    repeat (cpb / 2 - 1) @(posedge clk);
    if (tx !== 1'b0) begin
      stop_on_failure("start bit on tx did not last to mid-bit");
    end else begin
      for (int i = 0; i < 8; i++) begin
        repeat (cpb) @(posedge clk);
        got.data[i] = tx;
      end
      repeat (cpb) @(posedge clk);
      if (tx !== 1'b1) begin
        stop_on_failure("stop bit on tx is low");
      end else if (exp_q.size() == 0 || dut_mode_q.size() == 0) begin
        stop_on_failure("byte came out on tx when none was expected");
      end else begin
        exp = exp_q.pop_front();
        exp_mode = exp_mode_q.pop_front();
        dut_mode = dut_mode_q.pop_front();
        compare_byte("tx byte", got, exp);
        compare_mode("transform mode", dut_mode, exp_mode);
      end
    end
  endtask

  // tx monitor
  always begin
    @(posedge clk);
    if (!rst && tx === 1'b0) begin
      receive_frame();
    end
  end

  // mode in force as each data byte leaves the transform
  always @(posedge clk) begin
    if (!rst && uart_xform_top_i.byte_transform_i.send) begin
      dut_mode_q.push_back(uart_xform_top_i.byte_transform_i.mode);
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      if (frame_err) begin
        frame_err_count <= frame_err_count + 1;
      end
      if (overrun) begin
        overrun_count <= overrun_count + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      stop_on_failure($sformatf("timeout after %0d cycles, tx output never finished",
                                cycle_count));
    end
  end

  initial begin
    logic [31:0] r;
    int          err_before;
    clk = 1'b0;
    rst = 1'b1;
    rx = 1'b1;
    seed = seed_init;
    model_mode = xform_pass;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);

    // pass-through before any command
    for (int i = 0; i < n_pass; i++) begin
      send_byte(random_data(), 1);
    end
    wait_drain();

    // each command followed by a short text
    for (int c = 0; c < 4; c++) begin
      send_byte(cmd_seq[c], 1);
      for (int t = 0; t < 5; t++) begin
        send_byte(text[t], 1);
      end
    end
    wait_drain();

    // random mixed stream with one or two idle bits between frames
    for (int i = 0; i < n_random; i++) begin
      r = $random(seed);
      send_byte(random_byte(), r[0] ? 2 : 1);
    end
    wait_drain();

    // low stop bit then a good frame
    err_before = frame_err_count;
    drive_frame(random_data(), 1'b0, 1);
    send_byte(8'h71, 1);
    wait_drain();
    compare_count("frame_err pulses", frame_err_count - err_before, 1);

    // back to back at line rate
    for (int i = 0; i < n_burst; i++) begin
      send_byte(random_byte(), (i == n_burst - 1) ? 1 : 0);
    end
    wait_drain();
    compare_count("overrun pulses", overrun_count, 0);

    if (exp_q.size() != 0 || dut_mode_q.size() != 0) begin
      stop_on_failure("bytes left over in the model queue at the end");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

//--- verilog.f
+incdir+.
line_pkg.sv
xform_pkg.sv
uart_rx.sv
byte_transform.sv
uart_tx.sv
uart_xform_top.sv
uart_xform_properties.sv
tb_uart_xform.sv

//--- Makefile
TOP = tb_uart_xform

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
